/* sources.f */
hw/decode_pkg.sv
hw/reg_pkg.sv
hw/modrm_if.sv
hw/opcode_classifier.sv
hw/modrm_fields.sv
hw/ea_select.sv
hw/operand_select.sv
hw/instr_decode_top.sv
verification/instr_decode_tb.sv

/* Bender.yml */
package:
  name: instr_decode

sources:
  - files:
      - hw/decode_pkg.sv
      - hw/reg_pkg.sv
      - hw/modrm_if.sv
      - hw/opcode_classifier.sv
      - hw/modrm_fields.sv
      - hw/ea_select.sv
      - hw/operand_select.sv
      - hw/instr_decode_top.sv
  - target: simulation
    files:
      - verification/instr_decode_tb.sv

/* verification/instr_decode_tb.sv */
// ###################################################################
// Directed testbench for the 8086 first-byte and ModR/M decoder
// Reference rules per opcode family, streaming and EA table checks
// ###################################################################
`timescale 1ns/1ps
`default_nettype none

module instr_decode_tb;
    import decode_pkg::*;
    import reg_pkg::*;

    localparam int MAX_CYCLES = 2000;   // Directed run takes about 400 cycles

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    byte_t   opcode;
    byte_t   modrm;
    logic    out_valid;
    logic    need_modrm;
    logic    need_disp;
    logic    disp_size;
    logic    need_imm;
    logic    imm_size;
    logic    byte_word_field;
    reg_id_t src;
    reg_id_t dst;
    reg_id_t base;
    reg_id_t index;
    seg_t    seg;

    integer  seed = 75480;
    int      cycles = 0;
    int      errors;
    int      tests_run;
    logic    pend_valid;    // Pair driven last cycle, due at the outputs now
    byte_t   pend_op;
    byte_t   pend_mrm;

    instr_decode_top instr_decode_top_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .opcode          (opcode),
        .modrm           (modrm),
        .out_valid       (out_valid),
        .need_modrm      (need_modrm),
        .need_disp       (need_disp),
        .disp_size       (disp_size),
        .need_imm        (need_imm),
        .imm_size        (imm_size),
        .byte_word_field (byte_word_field),
        .src             (src),
        .dst             (dst),
        .base            (base),
        .index           (index),
        .seg             (seg)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic byte_t rand_byte();
        return $random(seed);
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERR %s exp %h got %h (opcode %h modrm %h)",
                     name, exp, act, pend_op, pend_mrm);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input reg_id_t exp, input reg_id_t act);
        if (act !== exp)
        begin
            $display("ERR %s exp %h got %h (opcode %h modrm %h)",
                     name, exp, act, pend_op, pend_mrm);
            errors++;
        end
    endtask

    task automatic check_seg(input string name, input seg_t exp, input seg_t act);
        if (act !== exp)
        begin
            $display("ERR %s exp %h got %h (opcode %h modrm %h)",
                     name, exp, act, pend_op, pend_mrm);
            errors++;
        end
    endtask

    // Opcode families by hex range
    function automatic op_class_e expected_class(input byte_t op);
        op_class_e c;
        c = OPC_NONE;
        if (op <= 8'h3F && !op[2])
            c = OPC_RM_R;
        else if ((op <= 8'h3F && op[2:1] == 2'b10) || op == 8'hA8 || op == 8'hA9)
            c = OPC_ACC_IMM;
        else if (op >= 8'h70 && op <= 8'h7F)
            c = OPC_BRANCH_SHORT;
        else if (op >= 8'h80 && op <= 8'h83)
            c = OPC_GRP_IMM;
        else if (op >= 8'h84 && op <= 8'h8B)
            c = OPC_RM_R;
        else if (op == 8'h8D)
            c = OPC_LEA;
        else if (op == 8'h8F)
            c = OPC_POP_RM;
        else if (op >= 8'h90 && op <= 8'h97)
            c = OPC_XCHG_ACC;
        else if (op >= 8'hA0 && op <= 8'hA3)
            c = OPC_MOV_M_ACC;
        else if (op >= 8'hB0 && op <= 8'hBF)
            c = OPC_MOV_R_IMM;
        else if (op == 8'hC0 || op == 8'hC1)
            c = OPC_SHIFT_IMM;
        else if (op == 8'hC2)
            c = OPC_RET_IMM;
        else if (op == 8'hC4 || op == 8'hC5)
            c = OPC_LES_LDS;
        else if (op == 8'hC6 || op == 8'hC7)
            c = OPC_MOV_RM_IMM;
        return c;
    endfunction

    task automatic check_decode(input byte_t op, input byte_t mrm);
        op_class_e  cls;
        logic [1:0] md;
        reg_id_t    rm_id;
        reg_id_t    dst_ord;
        reg_id_t    src_ord;
        logic       direct;
        logic       e_modrm;
        logic       e_disp;
        logic       e_dsize;
        logic       e_imm;
        logic       e_isize;
        logic       e_w;
        reg_id_t    e_src;
        reg_id_t    e_dst;
        reg_id_t    e_base;
        reg_id_t    e_index;
        cls     = expected_class(op);
        md      = mrm[7:6];
        rm_id   = {1'b0, mrm[2:0]};
        dst_ord = op[1] ? {1'b0, mrm[5:3]} : rm_id;   // D set puts reg first
        src_ord = op[1] ? rm_id : {1'b0, mrm[5:3]};
        direct  = (md == 2'd0) && (mrm[2:0] == 3'd6);
        e_w     = ((op >= 8'hB0 && op <= 8'hBF) || (op >= 8'h8C && op <= 8'h8F)) ?
                  op[3] : op[0];
        e_modrm = (cls == OPC_RM_R) || (cls == OPC_GRP_IMM) || (cls == OPC_MOV_RM_IMM) ||
                  (cls == OPC_LEA) || (cls == OPC_POP_RM) || (cls == OPC_SHIFT_IMM) ||
                  (cls == OPC_LES_LDS);
        e_disp  = e_modrm && (direct || md == 2'd1 || md == 2'd2);
        e_dsize = e_modrm && (direct || md == 2'd2);
        e_imm   = 1'b0;
        e_isize = 1'b0;
        e_src   = '0;
        e_dst   = '0;
        case (cls)
            OPC_RM_R:
            begin
                e_dst = dst_ord;
                e_src = src_ord;
            end
            OPC_ACC_IMM:      {e_imm, e_isize} = {1'b1, op[0]};
            OPC_GRP_IMM:      {e_imm, e_isize, e_dst} = {1'b1, op[0] & ~op[1], rm_id};
            OPC_MOV_R_IMM:    {e_imm, e_isize, e_dst} = {1'b1, op[3], 1'b0, op[2:0]};
            OPC_MOV_RM_IMM:   {e_imm, e_isize, e_dst} = {1'b1, op[0], rm_id};
            OPC_SHIFT_IMM:    {e_imm, e_dst, e_src} = {1'b1, rm_id, rm_id};
            OPC_RET_IMM:      {e_imm, e_isize} = 2'b11;
            OPC_LEA:          e_dst = dst_ord;
            OPC_POP_RM:       e_dst = rm_id;
            OPC_LES_LDS:      e_src = src_ord;
            OPC_XCHG_ACC:     e_src = {1'b0, op[2:0]};
            OPC_BRANCH_SHORT: {e_disp, e_dsize} = 2'b10;
            OPC_MOV_M_ACC:    {e_disp, e_dsize} = 2'b11;
            default: ;
        endcase
        // EA registers come from rm and mod in every class
        if (mrm[2:0] <= 3'd1 || mrm[2:0] == 3'd7)
            e_base = REG_BX;
        else if (mrm[2:0] <= 3'd3 || (mrm[2:0] == 3'd6 && md != 2'd0))
            e_base = REG_BP;
        else
            e_base = REG_NONE;
        e_index = (mrm[2:0] >= 3'd6) ? REG_NONE : (mrm[0] ? REG_DI : REG_SI);
        check_bit("need_modrm", e_modrm, need_modrm);
        check_bit("need_disp", e_disp, need_disp);
        check_bit("disp_size", e_dsize, disp_size);
        check_bit("need_imm", e_imm, need_imm);
        check_bit("imm_size", e_isize, imm_size);
        check_bit("byte_word_field", e_w, byte_word_field);
        check_reg("src", e_src, src);
        check_reg("dst", e_dst, dst);
        check_reg("base", e_base, base);
        check_reg("index", e_index, index);
        check_seg("seg", (e_base == REG_BP) ? SEG_SS : SEG_DS, seg);   // BP means stack
    endtask

    // Checks last cycle's pair, then drives the next one
    task automatic step(input logic valid, input byte_t op, input byte_t mrm);
        @(negedge clk);
        check_bit("out_valid", pend_valid, out_valid);
        if (pend_valid)
            check_decode(pend_op, pend_mrm);
        in_valid   = valid;
        opcode     = op;
        modrm      = mrm;
        pend_valid = valid;
        pend_op    = op;
        pend_mrm   = mrm;
    endtask

    task automatic send_one(input byte_t op, input byte_t mrm);
        step(1'b1, op, mrm);
        step(1'b0, 8'h00, 8'h00);
    endtask

    task automatic report_test(input string name, input int start);
        tests_run++;
        $display("test %-16s done, %0d errors", name, errors - start);
    endtask

    task automatic test_reset_strobe();
        int start;
        start = errors;
        rst_n    = 1'b0;
        in_valid = 1'b1;   // Strobe high while reset holds out_valid low
        opcode   = 8'h01;
        modrm    = 8'hC0;
        repeat (5)
        begin
            @(negedge clk);
            check_bit("out_valid", 1'b0, out_valid);
        end
        rst_n    = 1'b1;
        in_valid = 1'b0;
        step(1'b0, 8'h00, 8'h00);
        step(1'b1, 8'h01, 8'hC0);
        step(1'b0, 8'h00, 8'h00);
        step(1'b0, 8'h00, 8'h00);
        step(1'b1, 8'h8B, 8'h46);   // Back to back pulses
        step(1'b1, 8'h05, 8'h00);
        step(1'b0, 8'h00, 8'h00);
        step(1'b0, 8'h00, 8'h00);
        report_test("reset_strobe", start);
    endtask

    task automatic test_rm_r_forms();
        int    start;
        byte_t ops[40];
        start = errors;
        for (int g = 0; g < 8; g++)
            for (int k = 0; k < 4; k++)
                ops[g * 4 + k] = g * 8 + k;
        for (int k = 0; k < 8; k++)
            ops[32 + k] = 8'h84 + k;
        for (int i = 0; i < 50; i++)
            send_one(ops[i % 40], rand_byte());
        report_test("rm_r_forms", start);
    endtask

    task automatic test_imm_forms();
        int start;
        start = errors;
        for (int g = 0; g < 8; g++)
        begin
            send_one(g * 8 + 4, rand_byte());
            send_one(g * 8 + 5, rand_byte());
        end
        send_one(8'hA8, rand_byte());
        send_one(8'hA9, rand_byte());
        for (int k = 0; k < 4; k++)
            send_one(8'h80 + k, rand_byte());
        for (int k = 0; k < 16; k++)
            send_one(8'hB0 + k, rand_byte());
        send_one(8'hC6, rand_byte());
        send_one(8'hC7, rand_byte());
        send_one(8'hC0, rand_byte());
        send_one(8'hC1, rand_byte());
        report_test("imm_forms", start);
    endtask

    task automatic test_ea_table();
        int start;
        start = errors;
        for (int m = 0; m < 4; m++)
            for (int r = 0; r < 8; r++)
                send_one(8'h8B, {m[1:0], 3'b101, r[2:0]});
        report_test("ea_table", start);
    endtask

    task automatic test_special();
        int start;
        start = errors;
        for (int k = 0; k < 16; k++)
            send_one(8'h70 + k, rand_byte());
        for (int k = 0; k < 4; k++)
            send_one(8'hA0 + k, rand_byte());
        for (int k = 0; k < 8; k++)
            send_one(8'h90 + k, rand_byte());
        send_one(8'hC2, rand_byte());
        send_one(8'h8D, rand_byte());
        send_one(8'h8F, rand_byte());
        send_one(8'hC4, rand_byte());
        send_one(8'hC5, rand_byte());
        send_one(8'h06, rand_byte());   // No operands at all
        send_one(8'h26, rand_byte());
        send_one(8'h40, rand_byte());
        send_one(8'hF4, rand_byte());
        send_one(8'h8C, rand_byte());   // W from bit 3, bit 0 clear
        report_test("special", start);
    endtask

    task automatic test_streaming();
        int start;
        start = errors;
        for (int i = 0; i < 40; i++)
            step(1'b1, rand_byte(), rand_byte());
        step(1'b0, 8'h00, 8'h00);
        report_test("streaming", start);
    endtask

    initial
    begin
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        opcode     = 8'h00;
        modrm      = 8'h00;
        pend_valid = 1'b0;
        pend_op    = 8'h00;
        pend_mrm   = 8'h00;
        errors     = 0;
        tests_run  = 0;
        test_reset_strobe();
        test_rm_r_forms();
        test_imm_forms();
        test_ea_table();
        test_special();
        test_streaming();
        step(1'b0, 8'h00, 8'h00);
        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/instr_decode_top.sv */
// ###################################################################
// 8086 first-byte and ModR/M decoder top
// One input stage register feeding the combinational decoder
// ###################################################################
`timescale 1ns/1ps
`default_nettype none

module instr_decode_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  decode_pkg::byte_t opcode,
    input  decode_pkg::byte_t modrm,
    output logic              out_valid,
    output logic              need_modrm,
    output logic              need_disp,
    output logic              disp_size,
    output logic              need_imm,
    output logic              imm_size,
    output logic              byte_word_field,
    output reg_pkg::reg_id_t  src,
    output reg_pkg::reg_id_t  dst,
    output reg_pkg::reg_id_t  base,
    output reg_pkg::reg_id_t  index,
    output reg_pkg::seg_t     seg
);
    import decode_pkg::*;

    byte_t     opcode_q;     // Held byte pair
    byte_t     modrm_q;
    op_class_e op_class;
    logic      w_bit;
    logic      imm_wide;
    rm_t       opcode_reg;
    logic      d_bit;

    modrm_if fields_if ();

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            opcode_q  <= '0;
            modrm_q   <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= in_valid;
            if (in_valid)
            begin
                opcode_q <= opcode;
                modrm_q  <= modrm;
            end
        end
    end

    assign opcode_reg = opcode_q[RM_W-1:0];
    assign d_bit      = opcode_q[D_BIT_POS];

    opcode_classifier classifier_i (
        .opcode   (opcode_q),
        .op_class (op_class),
        .w_bit    (w_bit),
        .imm_wide (imm_wide)
    );

    modrm_fields modrm_fields_i (
        .modrm  (modrm_q),
        .d_bit  (d_bit),
        .fields (fields_if.producer)
    );

    ea_select ea_select_i (
        .fields (fields_if.consumer),
        .base   (base),
        .index  (index),
        .seg    (seg)
    );

    operand_select operand_select_i (
        .op_class        (op_class),
        .w_bit           (w_bit),
        .imm_wide        (imm_wide),
        .opcode_reg      (opcode_reg),
        .fields          (fields_if.consumer),
        .need_modrm      (need_modrm),
        .need_disp       (need_disp),
        .disp_size       (disp_size),
        .need_imm        (need_imm),
        .imm_size        (imm_size),
        .byte_word_field (byte_word_field),
        .src             (src),
        .dst             (dst)
    );

endmodule

`default_nettype wire

/* hw/operand_select.sv */
// ###################################################################
// Operand select
// Class plus ModR/M fields give need flags, sizes and operand ids
// ###################################################################
`timescale 1ns/1ps
`default_nettype none

module operand_select (
    input  decode_pkg::op_class_e op_class,
    input  logic                  w_bit,
    input  logic                  imm_wide,
    input  decode_pkg::rm_t       opcode_reg,
    modrm_if.consumer             fields,
    output logic                  need_modrm,
    output logic                  need_disp,
    output logic                  disp_size,
    output logic                  need_imm,
    output logic                  imm_size,
    output logic                  byte_word_field,
    output reg_pkg::reg_id_t      src,
    output reg_pkg::reg_id_t      dst
);
    import decode_pkg::*;
    import reg_pkg::*;

    reg_id_t dst_ord;   // Operands after D-bit ordering
    reg_id_t src_ord;
    reg_id_t rm_id;
    reg_id_t op_id;     // Register from the opcode low bits

    assign dst_ord = {1'b0, fields.dst_field};
    assign src_ord = {1'b0, fields.src_field};
    assign rm_id   = {1'b0, fields.rm};
    assign op_id   = {1'b0, opcode_reg};

    always_comb
    begin
        need_modrm = 1'b0;
        need_disp  = 1'b0;
        disp_size  = 1'b0;
        need_imm   = 1'b0;
        dst        = '0;
        src        = '0;

        // All ModR/M forms take their displacement from mod and rm
        case (op_class)
            OPC_RM_R, OPC_GRP_IMM, OPC_MOV_RM_IMM, OPC_LEA,
            OPC_POP_RM, OPC_SHIFT_IMM, OPC_LES_LDS:
            begin
                need_modrm = 1'b1;
                need_disp  = fields.disp_by_mod;
                disp_size  = fields.disp_wide;
            end
            default: ;
        endcase

        case (op_class)
            OPC_RM_R:
            begin
                dst = dst_ord;
                src = src_ord;
            end
            OPC_ACC_IMM, OPC_RET_IMM:  need_imm = 1'b1;
            OPC_GRP_IMM, OPC_MOV_RM_IMM:
            begin
                need_imm = 1'b1;
                dst      = rm_id;
            end
            OPC_MOV_R_IMM:
            begin
                need_imm = 1'b1;
                dst      = op_id;
            end
            OPC_LEA:       dst = dst_ord;
            OPC_POP_RM:    dst = rm_id;
            OPC_XCHG_ACC:  src = op_id;     // Swapped with AX
            OPC_SHIFT_IMM:
            begin
                need_imm = 1'b1;            // Shift count byte
                dst      = rm_id;
                src      = rm_id;
            end
            OPC_LES_LDS:   src = src_ord;
            OPC_BRANCH_SHORT:
            begin
                need_disp = 1'b1;           // 8-bit relative offset
                disp_size = 1'b0;
            end
            OPC_MOV_M_ACC:
            begin
                need_disp = 1'b1;
                disp_size = 1'b1;           // Full 16-bit address
            end
            default: ;
        endcase
    end

    assign imm_size        = need_imm && imm_wide;
    assign byte_word_field = w_bit;

endmodule

`default_nettype wire

/* hw/ea_select.sv */
// ###################################################################
// Effective address register select
// Maps rm and mod to base, index and segment registers
// ###################################################################
`timescale 1ns/1ps
`default_nettype none

module ea_select (
    modrm_if.consumer       fields,
    output reg_pkg::reg_id_t base,
    output reg_pkg::reg_id_t index,
    output reg_pkg::seg_t    seg
);
    import reg_pkg::*;

    logic mod_nonzero;

    assign mod_nonzero = (fields.mod != 2'b00);

    always_comb
    begin
        base  = REG_NONE;
        index = REG_NONE;
        seg   = SEG_DS;
        case (fields.rm)
            3'd0:
            begin
                base  = REG_BX;
                index = REG_SI;
            end
            3'd1:
            begin
                base  = REG_BX;
                index = REG_DI;
            end
            3'd2:
            begin
                base  = REG_BP;
                index = REG_SI;
                seg   = SEG_SS;   // BP addresses the stack
            end
            3'd3:
            begin
                base  = REG_BP;
                index = REG_DI;
                seg   = SEG_SS;
            end
            3'd4:    index = REG_SI;
            3'd5:    index = REG_DI;
            3'd6:
            begin
                // Direct address has neither base nor index
                if (mod_nonzero)
                begin
                    base = REG_BP;
                    seg  = SEG_SS;
                end
            end
            default: base = REG_BX;   // rm 7
        endcase
    end

endmodule

`default_nettype wire

/* hw/modrm_fields.sv */
// ###################################################################
// ModR/M field splitter
// Orders reg and rm by the D bit, works out the displacement size
// ###################################################################
`timescale 1ns/1ps
`default_nettype none

module modrm_fields (
    input  decode_pkg::byte_t modrm,
    input  logic              d_bit,
    modrm_if.producer         fields
);
    import decode_pkg::*;

    logic direct_addr;

    assign fields.mod       = modrm[7:6];
    assign fields.reg_field = modrm[5:3];
    assign fields.rm        = modrm[2:0];

    // D set means reg is the destination
    assign fields.dst_field = d_bit ? fields.reg_field : fields.rm;
    assign fields.src_field = d_bit ? fields.rm : fields.reg_field;

    // mod 0 with rm 6 is a plain 16-bit address
    assign direct_addr = (fields.mod == MOD_MEM) && (fields.rm == RM_DIRECT);

    assign fields.disp_by_mod = direct_addr ||
                                ((fields.mod != MOD_MEM) && (fields.mod != MOD_REG));
    assign fields.disp_wide   = direct_addr || (fields.mod == MOD_DISP16);

endmodule

`default_nettype wire

/* hw/opcode_classifier.sv */
// ###################################################################
// Opcode classifier
// Sorts the first byte into a class, derives W and immediate width
// ###################################################################
`timescale 1ns/1ps
`default_nettype none

module opcode_classifier (
    input  decode_pkg::byte_t     opcode,
    output decode_pkg::op_class_e op_class,
    output logic                  w_bit,
    output logic                  imm_wide
);
    import decode_pkg::*;

    logic w_from_alt;   // W sits in bit 3 for these opcodes

    always_comb
    begin
        casez (opcode)
            PAT_ALU_RM_R,
            PAT_TEST_XCHG,
            PAT_MOV_RM_R:   op_class = OPC_RM_R;
            PAT_ALU_ACC,
            PAT_TEST_ACC:   op_class = OPC_ACC_IMM;
            PAT_BRANCH:     op_class = OPC_BRANCH_SHORT;
            PAT_GRP_IMM:    op_class = OPC_GRP_IMM;
            PAT_LEA:        op_class = OPC_LEA;
            PAT_POP_RM:     op_class = OPC_POP_RM;
            PAT_XCHG_ACC:   op_class = OPC_XCHG_ACC;   // 90 is NOP
            PAT_MOV_M_ACC:  op_class = OPC_MOV_M_ACC;
            PAT_MOV_R_IMM:  op_class = OPC_MOV_R_IMM;
            PAT_SHIFT_IMM:  op_class = OPC_SHIFT_IMM;
            PAT_RET_IMM:    op_class = OPC_RET_IMM;
            PAT_LES_LDS:    op_class = OPC_LES_LDS;
            PAT_MOV_RM_IMM: op_class = OPC_MOV_RM_IMM;
            default:        op_class = OPC_NONE;       // Prefixes, stack, strings, flags
        endcase
    end

    assign w_from_alt = (opcode ==? PAT_MOV_R_IMM) || (opcode ==? PAT_W_ALT_GRP);
    assign w_bit      = w_from_alt ? opcode[W_ALT_POS] : opcode[W_BIT_POS];

    // Width of the immediate data that follows
    always_comb
    begin
        case (op_class)
            OPC_ACC_IMM,
            OPC_MOV_RM_IMM:
            begin
                imm_wide = opcode[W_BIT_POS];
            end
            OPC_GRP_IMM:
            begin
                // 83 sign-extends a byte immediate
                imm_wide = !opcode[D_BIT_POS] && opcode[W_BIT_POS];
            end
            OPC_MOV_R_IMM:
            begin
                imm_wide = opcode[W_ALT_POS];
            end
            OPC_RET_IMM:
            begin
                imm_wide = 1'b1;   // Pop count is always a word
            end
            default:
            begin
                imm_wide = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/modrm_if.sv */
// ###################################################################
// ModR/M field bundle
// Split fields plus displacement flags derived from mod and rm
// ###################################################################
`timescale 1ns/1ps
`default_nettype none

interface modrm_if ();
    import decode_pkg::*;

    mod_t mod;
    rm_t  reg_field;
    rm_t  rm;
    rm_t  dst_field;    // Ordered by the D bit
    rm_t  src_field;
    logic disp_by_mod;  // Displacement byte(s) follow
    logic disp_wide;    // 16-bit displacement

    modport producer (output mod, reg_field, rm, dst_field, src_field,
                      disp_by_mod, disp_wide);

    modport consumer (input mod, reg_field, rm, dst_field, src_field,
                      disp_by_mod, disp_wide);

endinterface

`default_nettype wire

/* hw/reg_pkg.sv */
// ###################################################################
// Register package with register and segment ids
// Address registers and the "not used" code
// ###################################################################
`default_nettype none

package reg_pkg;

    localparam int REG_ID_W = 4;
    localparam int SEG_W    = 2;

    // High bit set means the register takes no part
    typedef logic [REG_ID_W-1:0] reg_id_t;
    typedef logic [SEG_W-1:0]    seg_t;

    localparam reg_id_t REG_BX   = 4'd3;
    localparam reg_id_t REG_BP   = 4'd5;
    localparam reg_id_t REG_SI   = 4'd6;
    localparam reg_id_t REG_DI   = 4'd7;
    localparam reg_id_t REG_NONE = 4'b1100;

    localparam seg_t SEG_SS = 2'd2;
    localparam seg_t SEG_DS = 2'd3;   // Default data segment

endpackage

`default_nettype wire

/* hw/decode_pkg.sv */
// ###################################################################
// Decoder package for the 8086 first-byte decoder
// Instruction classes, ModR/M field types and opcode match patterns
// ###################################################################
`default_nettype none

package decode_pkg;

    localparam int BYTE_W = 8;
    localparam int MOD_W  = 2;
    localparam int RM_W   = 3;

    typedef logic [BYTE_W-1:0] byte_t;   // One instruction byte
    typedef logic [MOD_W-1:0]  mod_t;
    typedef logic [RM_W-1:0]   rm_t;

    // One value per decoded instruction family
    typedef enum logic [3:0] {
        OPC_NONE,
        OPC_RM_R,          // ALU, TEST, XCHG and MOV between R/M and R
        OPC_ACC_IMM,
        OPC_GRP_IMM,       // 80..83
        OPC_MOV_R_IMM,
        OPC_MOV_RM_IMM,
        OPC_LEA,
        OPC_POP_RM,
        OPC_XCHG_ACC,
        OPC_SHIFT_IMM,
        OPC_LES_LDS,
        OPC_BRANCH_SHORT,
        OPC_RET_IMM,
        OPC_MOV_M_ACC
    } op_class_e;

    localparam mod_t MOD_MEM    = 2'd0;
    localparam mod_t MOD_DISP16 = 2'd2;
    localparam mod_t MOD_REG    = 2'd3;   // Register direct
    localparam rm_t  RM_DIRECT  = 3'd6;   // Direct address when mod is 0

    // Bit positions inside the opcode byte
    localparam int D_BIT_POS  = 1;
    localparam int W_BIT_POS  = 0;
    localparam int W_ALT_POS  = 3;        // W of B0..BF and 8C..8F

    // Opcode patterns for casez and wildcard compares
    localparam byte_t PAT_ALU_RM_R   = 8'b00??_?0??;
    localparam byte_t PAT_ALU_ACC    = 8'b00??_?10?;
    localparam byte_t PAT_BRANCH     = 8'b0111_????;
    localparam byte_t PAT_GRP_IMM    = 8'b1000_00??;
    localparam byte_t PAT_TEST_XCHG  = 8'b1000_01??;
    localparam byte_t PAT_MOV_RM_R   = 8'b1000_10??;
    localparam byte_t PAT_W_ALT_GRP  = 8'b1000_11??;
    localparam byte_t PAT_LEA        = 8'b1000_1101;
    localparam byte_t PAT_POP_RM     = 8'b1000_1111;
    localparam byte_t PAT_XCHG_ACC   = 8'b1001_0???;
    localparam byte_t PAT_MOV_M_ACC  = 8'b1010_00??;
    localparam byte_t PAT_TEST_ACC   = 8'b1010_100?;
    localparam byte_t PAT_MOV_R_IMM  = 8'b1011_????;
    localparam byte_t PAT_SHIFT_IMM  = 8'b1100_000?;
    localparam byte_t PAT_RET_IMM    = 8'b1100_0010;
    localparam byte_t PAT_LES_LDS    = 8'b1100_010?;
    localparam byte_t PAT_MOV_RM_IMM = 8'b1100_011?;

endpackage

`default_nettype wire
